// File: design/rmt_pkg.sv
package rmt_pkg;

	// stream geometry
	localparam int DATA_W = 64;
	localparam int KEEP_W = DATA_W / 8;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [KEEP_W-1:0] keep_t;

	// header fields, top of the first beat
	localparam int VLAN_W  = 12;
	localparam int FIELD_W = 16;
	localparam int PHV_W   = VLAN_W + 2 * FIELD_W;
	typedef logic [VLAN_W-1:0]  vlan_t;
	typedef logic [FIELD_W-1:0] field_t;
	typedef logic [PHV_W-1:0]   phv_t;   // {vlan, f0, f1}

	localparam int VLAN_LSB = 52;
	localparam int F0_LSB   = 36;
	localparam int F1_LSB   = 20;

	// field offsets inside phv_t
	localparam int PHV_VLAN_LSB = 2 * FIELD_W;
	localparam int PHV_F0_LSB   = FIELD_W;
	localparam int PHV_F1_LSB   = 0;

	localparam vlan_t CTRL_VLAN = '1;

	localparam int N_STAGES   = 2;
	localparam int STAGE_ID_W = 4;
	localparam int TBL_DEPTH  = 16;
	localparam int TBL_IDX_W  = 4;   // low VLAN bits index the table

	localparam int OP_W  = 2;
	localparam int ACT_W = OP_W + FIELD_W;
	typedef enum logic [OP_W-1:0] {ACT_NOP, ACT_ADD_F0, ACT_ADD_F1, ACT_SET_F0} act_op_t;
	typedef logic [ACT_W-1:0] action_t;   // {op, imm}

	// control beat layout
	localparam int CTL_STG_LSB = 48;
	localparam int CTL_IDX_LSB = 44;
	localparam int CTL_OP_LSB  = 42;
	localparam int CTL_IMM_LSB = 26;

	localparam int FIFO_DEPTH_BITS = 4;
	localparam int FIFO_MARGIN     = 4;   // PHVs that can still be in flight

endpackage

// File: design/stream_if.sv
`timescale 1ns/1ns

interface stream_if import rmt_pkg::*; ();
	data_t data;
	keep_t keep;
	logic  last;
	logic  valid;
	logic  ready;

	// beat moves on valid && ready
	modport src (
		output data, keep, last, valid,
		input  ready
	);

	modport dst (
		input  data, keep, last, valid,
		output ready
	);
endinterface

// File: design/pkt_filter.sv
`timescale 1ns/1ns

module pkt_filter import rmt_pkg::*; (
	input  logic                  clk,
	input  logic                  aresetn,
	input  logic [31:0]           vlan_drop_flags,
	input  data_t                 s_data,
	input  keep_t                 s_keep,
	input  logic                  s_last,
	input  logic                  s_valid,
	input  logic                  fifo_room,   // neither FIFO nearly full
	output logic                  s_ready,
	output logic [31:0]           ctrl_token,
	output logic                  ctl_wr,
	output logic [STAGE_ID_W-1:0] ctl_stage,
	output logic [TBL_IDX_W-1:0]  ctl_idx,
	output action_t               ctl_act,
	stream_if.src                 m
);
	typedef enum logic [1:0] {MODE_PASS, MODE_DROP, MODE_CTRL} mode_t;

	mode_t mode_q;
	mode_t mode_new;
	mode_t mode_cur;
	logic  first;
	logic  take;
	logic  ctl_hit;
	vlan_t s_vlan;

	assign s_vlan = s_data[VLAN_LSB +: VLAN_W];

	// stall on a held output beat, and leave a gap after each table write
	assign s_ready = fifo_room && (!m.valid || m.ready) && !ctl_wr;
	assign take    = s_valid && s_ready;

	always_comb begin
		if (s_vlan == CTRL_VLAN)
			mode_new = MODE_CTRL;
		else if (vlan_drop_flags[s_vlan[4:0]])   // one flag per low five VLAN bits
			mode_new = MODE_DROP;
		else
			mode_new = MODE_PASS;
	end

	// decision made on the first beat, kept until last
	assign mode_cur = first ? mode_new : mode_q;
	assign ctl_hit  = take && first && (mode_new == MODE_CTRL);

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			first  <= 1'b1;
			mode_q <= MODE_PASS;
		end else if (take) begin
			first  <= s_last;
			mode_q <= mode_cur;
		end
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			ctl_wr     <= 1'b0;
			ctrl_token <= '0;
		end else begin
			ctl_wr <= ctl_hit;
			if (ctl_hit)
				ctrl_token <= ctrl_token + 32'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (ctl_hit) begin
			ctl_stage <= s_data[CTL_STG_LSB +: STAGE_ID_W];
			ctl_idx   <= s_data[CTL_IDX_LSB +: TBL_IDX_W];
			ctl_act   <= {s_data[CTL_OP_LSB +: OP_W], s_data[CTL_IMM_LSB +: FIELD_W]};
		end
	end

	// output register for kept data beats
	always_ff @(posedge clk) begin
		if (!aresetn)
			m.valid <= 1'b0;
		else if (!m.valid || m.ready)
			m.valid <= take && (mode_cur == MODE_PASS);
	end

	always_ff @(posedge clk) begin
		if (take) begin
			m.data <= s_data;
			m.keep <= s_keep;
			m.last <= s_last;
		end
	end

	a_ctl_wr_gap: assert property (@(posedge clk) disable iff (!aresetn) ctl_wr |=> !ctl_wr);

endmodule

// File: design/phv_parser.sv
`timescale 1ns/1ns

module phv_parser import rmt_pkg::*; (
	input  logic   clk,
	input  logic   aresetn,
	stream_if.dst  s,
	stream_if.src  m,
	output phv_t   phv,
	output logic   phv_valid
);
	logic first;
	logic beat;

	// beats go straight on to the packet FIFO
	assign m.data  = s.data;
	assign m.keep  = s.keep;
	assign m.last  = s.last;
	assign m.valid = s.valid;
	assign s.ready = m.ready;

	assign beat = s.valid && s.ready;

	always_ff @(posedge clk) begin
		if (!aresetn)
			first <= 1'b1;
		else if (beat)
			first <= s.last;
	end

	always_ff @(posedge clk) begin
		if (!aresetn)
			phv_valid <= 1'b0;
		else
			phv_valid <= beat && first;
	end

	// vlan, f0, f1 sit contiguous at the top of the header beat
	always_ff @(posedge clk) begin
		if (beat && first)
			phv <= s.data[VLAN_LSB+VLAN_W-1 : F1_LSB];
	end

endmodule

// File: design/match_action_stage.sv
`timescale 1ns/1ns

module match_action_stage import rmt_pkg::*; #(
	parameter int STAGE_ID = 0
) (
	input  logic                  clk,
	input  logic                  aresetn,
	input  logic                  ctl_wr,
	input  logic [STAGE_ID_W-1:0] ctl_stage,
	input  logic [TBL_IDX_W-1:0]  ctl_idx,
	input  action_t               ctl_act,
	input  phv_t                  phv_in,
	input  logic                  phv_in_valid,
	output phv_t                  phv_out,
	output logic                  phv_out_valid
);
	action_t                act_tbl [TBL_DEPTH];
	action_t                act;
	act_op_t                op;
	field_t                 imm;
	field_t                 f0;
	field_t                 f1;
	logic [TBL_IDX_W-1:0]   idx;
	phv_t                   phv_nxt;

	// table write, only for this stage
	always_ff @(posedge clk) begin
		if (!aresetn) begin
			for (int i = 0; i < TBL_DEPTH; i++)
				act_tbl[i] <= {ACT_NOP, FIELD_W'(0)};
		end else if (ctl_wr && ctl_stage == STAGE_ID_W'(STAGE_ID)) begin
			act_tbl[ctl_idx] <= ctl_act;
		end
	end

	// direct lookup by low VLAN bits
	assign idx = phv_in[PHV_VLAN_LSB +: TBL_IDX_W];
	assign act = act_tbl[idx];
	assign op  = act_op_t'(act[ACT_W-1 -: OP_W]);
	assign imm = act[FIELD_W-1:0];
	assign f0  = phv_in[PHV_F0_LSB +: FIELD_W];
	assign f1  = phv_in[PHV_F1_LSB +: FIELD_W];

	always_comb begin
		phv_nxt = phv_in;
		case (op)
			ACT_ADD_F0: phv_nxt[PHV_F0_LSB +: FIELD_W] = f0 + imm;   // wraps at 16 bits
			ACT_ADD_F1: phv_nxt[PHV_F1_LSB +: FIELD_W] = f1 + imm;
			ACT_SET_F0: phv_nxt[PHV_F0_LSB +: FIELD_W] = imm;
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!aresetn)
			phv_out_valid <= 1'b0;
		else
			phv_out_valid <= phv_in_valid;
	end

	always_ff @(posedge clk) begin
		if (phv_in_valid)
			phv_out <= phv_nxt;
	end

endmodule

// File: design/sync_fifo.sv
`timescale 1ns/1ns

module sync_fifo import rmt_pkg::*; #(
	parameter int WIDTH      = 8,
	parameter int DEPTH_BITS = FIFO_DEPTH_BITS
) (
	input  logic             clk,
	input  logic             aresetn,
	input  logic [WIDTH-1:0] din,
	input  logic             wr_en,
	input  logic             rd_en,
	output logic [WIDTH-1:0] dout,
	output logic             empty,
	output logic             nearly_full
);
	logic [WIDTH-1:0]      mem [2**DEPTH_BITS];
	logic [DEPTH_BITS-1:0] wr_ptr;
	logic [DEPTH_BITS-1:0] rd_ptr;
	logic [DEPTH_BITS:0]   count;
	logic                  full;

	assign dout        = mem[rd_ptr];   // head is visible without a read
	assign empty       = (count == '0);
	assign full        = count[DEPTH_BITS];
	assign nearly_full = count >= (DEPTH_BITS+1)'(2**DEPTH_BITS - FIFO_MARGIN);

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	a_no_overflow:  assert property (@(posedge clk) disable iff (!aresetn) wr_en |-> !full);
	a_no_underflow: assert property (@(posedge clk) disable iff (!aresetn) rd_en |-> !empty);

endmodule

// File: design/deparser.sv
`timescale 1ns/1ns

module deparser import rmt_pkg::*; (
	input  logic   clk,
	input  logic   aresetn,
	input  data_t  pkt_data,
	input  keep_t  pkt_keep,
	input  logic   pkt_last,
	input  logic   pkt_empty,
	input  phv_t   phv,
	input  logic   phv_empty,
	output logic   pkt_rd,
	output logic   phv_rd,
	stream_if.src  m
);
	typedef enum logic {DP_HEAD, DP_BODY} dp_state_t;

	dp_state_t state;
	logic      out_free;
	data_t     out_data;

	assign out_free = !m.valid || m.ready;

	// header beat waits for its PHV as well
	always_comb begin
		pkt_rd = 1'b0;
		phv_rd = 1'b0;
		case (state)
			DP_HEAD: begin
				pkt_rd = out_free && !pkt_empty && !phv_empty;
				phv_rd = pkt_rd;
			end
			DP_BODY: pkt_rd = out_free && !pkt_empty;
			default: ;
		endcase
	end

	assign out_data = (state == DP_HEAD) ? {phv, pkt_data[F1_LSB-1:0]} : pkt_data;

	always_ff @(posedge clk) begin
		if (!aresetn)
			state <= DP_HEAD;
		else if (pkt_rd)
			state <= pkt_last ? DP_HEAD : DP_BODY;
	end

	always_ff @(posedge clk) begin
		if (!aresetn)
			m.valid <= 1'b0;
		else if (out_free)
			m.valid <= pkt_rd;
	end

	always_ff @(posedge clk) begin
		if (pkt_rd) begin
			m.data <= out_data;
			m.keep <= pkt_keep;
			m.last <= pkt_last;
		end
	end

endmodule

// File: design/rmt_pipeline.sv
`timescale 1ns/1ns

module rmt_pipeline import rmt_pkg::*; (
	input  logic        clk,
	input  logic        aresetn,
	input  logic [31:0] vlan_drop_flags,
	input  data_t       s_tdata,
	input  keep_t       s_tkeep,
	input  logic        s_tlast,
	input  logic        s_tvalid,
	output logic        s_tready,
	output data_t       m_tdata,
	output keep_t       m_tkeep,
	output logic        m_tlast,
	output logic        m_tvalid,
	input  logic        m_tready,
	output logic [31:0] ctrl_token
);
	stream_if flt_s ();   // filter -> parser
	stream_if prs_s ();   // parser -> packet FIFO
	stream_if pkt_s ();   // packet FIFO -> deparser
	stream_if out_s ();   // deparser -> output port

	logic                  ctl_wr;
	logic [STAGE_ID_W-1:0] ctl_stage;
	logic [TBL_IDX_W-1:0]  ctl_idx;
	action_t               ctl_act;
	phv_t                  stg_phv   [N_STAGES+1];
	logic                  stg_valid [N_STAGES+1];
	phv_t                  phv_q;
	logic                  pkt_empty, pkt_nearly_full;
	logic                  phv_empty, phv_nearly_full, phv_rd;

	pkt_filter u_filter (
		.clk, .aresetn, .vlan_drop_flags,
		.s_data(s_tdata), .s_keep(s_tkeep), .s_last(s_tlast), .s_valid(s_tvalid),
		.fifo_room(!pkt_nearly_full && !phv_nearly_full), .s_ready(s_tready),
		.ctrl_token, .ctl_wr, .ctl_stage, .ctl_idx, .ctl_act, .m(flt_s)
	);

	phv_parser u_parser (
		.clk, .aresetn, .s(flt_s), .m(prs_s), .phv(stg_phv[0]), .phv_valid(stg_valid[0])
	);

	for (genvar g = 0; g < N_STAGES; g++) begin : g_stage
		match_action_stage #(.STAGE_ID(g)) u_stage (
			.clk, .aresetn, .ctl_wr, .ctl_stage, .ctl_idx, .ctl_act,
			.phv_in(stg_phv[g]), .phv_in_valid(stg_valid[g]),
			.phv_out(stg_phv[g+1]), .phv_out_valid(stg_valid[g+1])
		);
	end

	assign prs_s.ready = !pkt_nearly_full;
	assign pkt_s.valid = !pkt_empty;

	sync_fifo #(.WIDTH(DATA_W + KEEP_W + 1)) u_pkt_fifo (
		.clk, .aresetn,
		.din({prs_s.data, prs_s.keep, prs_s.last}), .wr_en(prs_s.valid && prs_s.ready),
		.rd_en(pkt_s.ready), .dout({pkt_s.data, pkt_s.keep, pkt_s.last}),
		.empty(pkt_empty), .nearly_full(pkt_nearly_full)
	);

	sync_fifo #(.WIDTH(PHV_W)) u_phv_fifo (
		.clk, .aresetn, .din(stg_phv[N_STAGES]), .wr_en(stg_valid[N_STAGES]),
		.rd_en(phv_rd), .dout(phv_q), .empty(phv_empty), .nearly_full(phv_nearly_full)
	);

	deparser u_deparser (
		.clk, .aresetn, .pkt_data(pkt_s.data), .pkt_keep(pkt_s.keep), .pkt_last(pkt_s.last),
		.pkt_empty(!pkt_s.valid), .phv(phv_q), .phv_empty, .pkt_rd(pkt_s.ready), .phv_rd,
		.m(out_s)
	);

	assign m_tdata     = out_s.data;
	assign m_tkeep     = out_s.keep;
	assign m_tlast     = out_s.last;
	assign m_tvalid    = out_s.valid;
	assign out_s.ready = m_tready;

endmodule

// File: verif/rmt_checker.sv
`timescale 1ns/1ns

module rmt_checker import rmt_pkg::*; (
	input  logic        clk,
	input  logic        aresetn,
	input  logic [31:0] vlan_drop_flags,
	input  data_t       s_tdata,
	input  keep_t       s_tkeep,
	input  logic        s_tlast,
	input  logic        s_tvalid,
	input  logic        s_tready,
	input  data_t       m_tdata,
	input  keep_t       m_tkeep,
	input  logic        m_tlast,
	input  logic        m_tvalid,
	input  logic        m_tready,
	input  logic [31:0] ctrl_token,
	input  logic        report_req,
	output int          err_cnt,
	output int          exp_left
);
	typedef logic [DATA_W+KEEP_W:0] beat_t;   // {data, keep, last}

	beat_t           exp_q [$];
	logic [OP_W-1:0] tbl_op  [N_STAGES][TBL_DEPTH];
	field_t          tbl_imm [N_STAGES][TBL_DEPTH];
	logic            in_first;
	logic            in_keep;
	logic            held;
	logic            after_rst;
	beat_t           held_beat;
	logic [31:0]     exp_token;
	vlan_t           vlan;
	field_t          f0;
	field_t          f1;

	// header fields after one stage's action
	task automatic apply_stage(input int s, input vlan_t v, inout field_t a, inout field_t b);
		logic [OP_W-1:0] op;
		field_t          imm;
		op  = tbl_op[s][v[TBL_IDX_W-1:0]];
		imm = tbl_imm[s][v[TBL_IDX_W-1:0]];
		case (op)
			ACT_ADD_F0: a = a + imm;   // 16-bit wrap
			ACT_ADD_F1: b = b + imm;
			ACT_SET_F0: a = imm;
			default: ;
		endcase
	endtask

	// everything is stable at the falling edge
	always @(negedge clk) begin
		beat_t                got;
		int                   stg;
		logic [TBL_IDX_W-1:0] cidx;
		if (!aresetn) begin
			exp_q.delete();
			for (int s = 0; s < N_STAGES; s++)
				for (int i = 0; i < TBL_DEPTH; i++) begin
					tbl_op[s][i]  = ACT_NOP;
					tbl_imm[s][i] = '0;
				end
			in_first  = 1'b1;
			in_keep   = 1'b0;
			held      = 1'b0;
			after_rst = 1'b1;
			exp_token = '0;
			err_cnt   = 0;
		end else begin
			if (after_rst && m_tvalid !== 1'b0) begin
				$display("ERR %0t: m_tvalid high right after reset", $time);
				err_cnt++;
			end
			after_rst = 1'b0;
			if (ctrl_token !== exp_token) begin
				$display("ERR %0t: ctrl_token %0d exp %0d", $time, ctrl_token, exp_token);
				err_cnt++;
			end
			got = {m_tdata, m_tkeep, m_tlast};
			if (held && (!m_tvalid || got !== held_beat)) begin
				$display("ERR %0t: output beat changed while stalled", $time);
				err_cnt++;
			end
			if (m_tvalid && m_tready) begin
				if (exp_q.size() == 0) begin
					$display("ERR %0t: unexpected output beat %h", $time, got);
					err_cnt++;
				end else begin
					if (got !== exp_q[0]) begin
						$display("ERR %0t: beat got %h exp %h", $time, got, exp_q[0]);
						err_cnt++;
					end
					void'(exp_q.pop_front());
				end
			end
			held      = m_tvalid && !m_tready;
			held_beat = got;

			// input side: classify on first beat, model the tables
			if (s_tvalid && s_tready) begin
				if (in_first) begin
					vlan    = s_tdata[VLAN_LSB +: VLAN_W];
					f0      = s_tdata[F0_LSB +: FIELD_W];
					f1      = s_tdata[F1_LSB +: FIELD_W];
					in_keep = 1'b0;
					if (vlan == CTRL_VLAN) begin
						stg  = int'(s_tdata[CTL_STG_LSB +: STAGE_ID_W]);
						cidx = s_tdata[CTL_IDX_LSB +: TBL_IDX_W];
						if (stg < N_STAGES) begin
							tbl_op[stg][cidx]  = s_tdata[CTL_OP_LSB +: OP_W];
							tbl_imm[stg][cidx] = s_tdata[CTL_IMM_LSB +: FIELD_W];
						end
						exp_token = exp_token + 32'd1;
					end else if (!vlan_drop_flags[vlan[4:0]]) begin
						in_keep = 1'b1;
						for (int s = 0; s < N_STAGES; s++)
							apply_stage(s, vlan, f0, f1);   // stage 0 feeds stage 1
					end
				end
				if (in_keep && in_first)
					exp_q.push_back({vlan, f0, f1, s_tdata[F1_LSB-1:0], s_tkeep, s_tlast});
				else if (in_keep)
					exp_q.push_back({s_tdata, s_tkeep, s_tlast});
				in_first = s_tlast;
			end
		end
		exp_left = exp_q.size();
	end

	always @(posedge report_req) begin
		if (exp_left != 0)
			$display("%0d expected output beats never left the DUT", exp_left);
	end

endmodule

// File: verif/tb_rmt.sv
`timescale 1ns/1ns

module tb_rmt import rmt_pkg::*; ();
	localparam int N_ROWS = 16;
	localparam int SEED   = 90321;

	typedef struct packed {
		logic        ctl;
		vlan_t       vlan;
		field_t      f0;
		field_t      f1;
		logic [3:0]  beats;
		logic [3:0]  stg;
		logic [3:0]  idx;
		logic [1:0]  op;
		field_t      imm;
		logic [31:0] flags;
	} row_t;

	logic        clk;
	logic        aresetn;
	logic [31:0] vlan_drop_flags;
	data_t       s_tdata;
	keep_t       s_tkeep;
	logic        s_tlast;
	logic        s_tvalid;
	logic        s_tready;
	data_t       m_tdata;
	keep_t       m_tkeep;
	logic        m_tlast;
	logic        m_tvalid;
	logic        m_tready;
	logic [31:0] ctrl_token;
	logic        report_req;
	int          err_cnt;
	int          exp_left;
	row_t        rows [N_ROWS];
	logic [31:0] pay_state;
	logic [31:0] rdy_state;

	rmt_pipeline DUT (
		.clk, .aresetn, .vlan_drop_flags, .s_tdata, .s_tkeep, .s_tlast, .s_tvalid, .s_tready,
		.m_tdata, .m_tkeep, .m_tlast, .m_tvalid, .m_tready, .ctrl_token
	);

	rmt_checker chk (
		.clk, .aresetn, .vlan_drop_flags, .s_tdata, .s_tkeep, .s_tlast, .s_tvalid, .s_tready,
		.m_tdata, .m_tkeep, .m_tlast, .m_tvalid, .m_tready, .ctrl_token, .report_req,
		.err_cnt, .exp_left
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic data_t next_word();
		logic [31:0] hi;
		pay_state = lcg_next(pay_state);
		hi        = pay_state;
		pay_state = lcg_next(pay_state);
		return {hi, pay_state};
	endfunction

	function automatic row_t data_row(input vlan_t vlan, input field_t f0, input field_t f1,
			input int beats, input logic [31:0] flags);
		row_t r;
		r       = '0;
		r.vlan  = vlan;
		r.f0    = f0;
		r.f1    = f1;
		r.beats = 4'(beats);
		r.flags = flags;
		return r;
	endfunction

	function automatic row_t ctl_row(input int stg, input int idx, input act_op_t op,
			input field_t imm, input int beats);
		row_t r;
		r       = '0;
		r.ctl   = 1'b1;
		r.stg   = 4'(stg);
		r.idx   = 4'(idx);
		r.op    = op;
		r.imm   = imm;
		r.beats = 4'(beats);
		return r;
	endfunction

	// one packet, each beat held until taken
	task automatic send_row(input row_t r);
		data_t w;
		data_t hdr;
		w = next_word();
		if (r.ctl)
			hdr = {CTRL_VLAN, r.stg, r.idx, r.op, r.imm, w[25:0]};
		else
			hdr = {r.vlan, r.f0, r.f1, w[19:0]};
		vlan_drop_flags = r.flags;
		for (int b = 0; b < int'(r.beats); b++) begin
			s_tdata  = (b == 0) ? hdr : next_word();
			s_tlast  = (b == int'(r.beats) - 1);
			s_tkeep  = s_tlast ? (8'hFF >> pay_state[2:0]) : 8'hFF;
			s_tvalid = 1'b1;
			do
				@(negedge clk);
			while (!s_tready);
			@(posedge clk);
			#2;
		end
		s_tvalid = 1'b0;
		repeat (pay_state[5:4]) begin
			@(posedge clk);
			#2;
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// random output ready plus a long stall every 128 cycles
	initial begin
		int cyc;
		cyc       = 0;
		m_tready  = 1'b0;
		rdy_state = SEED;
		forever begin
			@(posedge clk);
			#2;
			rdy_state = lcg_next(rdy_state);
			m_tready  = (rdy_state[31:30] != 2'b00) && (cyc % 128 < 96);
			cyc++;
		end
	end

	initial begin
		repeat (200 * N_ROWS + 1000) @(posedge clk);
		$display("watchdog expired, %0d errors and %0d beats still expected", err_cnt, exp_left);
		$display("TB FAILED");
		$finish;
	end

	initial begin
		int n;
		aresetn         = 1'b0;
		vlan_drop_flags = '0;
		s_tdata         = '0;
		s_tkeep         = '0;
		s_tlast         = 1'b0;
		s_tvalid        = 1'b0;
		report_req      = 1'b0;
		pay_state       = SEED;

		rows[0]  = data_row(12'h010, 16'h1111, 16'h2222, 2, 32'h0);
		rows[1]  = data_row(12'h023, 16'h3333, 16'h4444, 3, 32'h8);    // dropped
		rows[2]  = data_row(12'h005, 16'h5555, 16'h6666, 1, 32'h8);
		rows[3]  = ctl_row(0, 1, ACT_ADD_F0, 16'h0010, 1);
		rows[4]  = data_row(12'h041, 16'hFFF8, 16'h0001, 2, 32'h0);    // f0 wraps
		rows[5]  = ctl_row(1, 2, ACT_ADD_F1, 16'h8000, 2);
		rows[6]  = data_row(12'h032, 16'h0ABC, 16'h9000, 3, 32'h0);    // f1 wraps
		rows[7]  = ctl_row(0, 7, ACT_SET_F0, 16'h1234, 1);
		rows[8]  = ctl_row(1, 7, ACT_ADD_F0, 16'h0100, 1);
		rows[9]  = data_row(12'h107, 16'h0000, 16'h7777, 4, 32'h0);    // set then add
		rows[10] = data_row(12'h0C7, 16'h0000, 16'h0000, 2, 32'h80);   // dropped
		rows[11] = data_row(12'h011, 16'h0001, 16'h0002, 5, 32'h80);
		rows[12] = ctl_row(0, 1, ACT_NOP, 16'h0000, 1);
		rows[13] = data_row(12'h061, 16'hABCD, 16'h1234, 6, 32'h0);
		rows[14] = data_row(12'h2A7, 16'hFFFF, 16'h0F0F, 8, 32'h0);
		rows[15] = data_row(12'h3F2, 16'h0102, 16'h8001, 7, 32'h0);

		repeat (10) @(posedge clk);
		#2;
		aresetn = 1'b1;
		repeat (3) @(posedge clk);
		#2;
		for (int r = 0; r < N_ROWS; r++)
			send_row(rows[r]);

		n = 0;
		while (exp_left != 0 && n < 500) begin
			@(posedge clk);
			n++;
		end
		repeat (20) @(posedge clk);   // catch stray beats
		#2;
		report_req = 1'b1;
		#1;
		$display("errors: %0d mismatches, %0d beats missing", err_cnt, exp_left);
		if (err_cnt == 0 && exp_left == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// File: list.f
design/rmt_pkg.sv
design/stream_if.sv
design/pkt_filter.sv
design/phv_parser.sv
design/match_action_stage.sv
design/sync_fifo.sv
design/deparser.sv
design/rmt_pipeline.sv
verif/rmt_checker.sv
verif/tb_rmt.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_rmt -o sim_rmt &&
	./obj_dir/sim_rmt | tee sim.log &&
	! grep -q "TB FAILED" sim.log &&
	grep -q "TB PASSED" sim.log &&
	echo "simulation passed" ||
	{ echo "simulation failed, see sim.log"; exit 1; }
